/* src.f */
common/io_pkg.sv
hw/uart/uart_baud_timer.sv
hw/uart/uart_tx_shift.sv
hw/uart/uart_tx_ctrl.sv
hw/interval_timer.sv
hw/io_bus_decoder.sv
hw/io_subsystem_top.sv
testbench/io_subsystem_props.sv
testbench/io_subsystem_tb.sv

/* Bender.yml */
package:
  name: io_subsystem

sources:
  - common/io_pkg.sv
  - hw/uart/uart_baud_timer.sv
  - hw/uart/uart_tx_shift.sv
  - hw/uart/uart_tx_ctrl.sv
  - hw/interval_timer.sv
  - hw/io_bus_decoder.sv
  - hw/io_subsystem_top.sv
  - target: test
    files:
      - testbench/io_subsystem_props.sv
      - testbench/io_subsystem_tb.sv

/* testbench/io_subsystem_tb.sv */
// Testbench for the I/O subsystem that walks a bus stimulus table and checks every output
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_tb;
    import io_pkg::*;

    localparam int CLOCKS_PER_BIT = 8;
    localparam int MAX_ROWS = 32;

    typedef enum int {OP_WRITE, OP_READ, OP_DISPLAY, OP_UART, OP_TIMER} op_t;

    logic clk = 1'b0;
    logic reset = 1'b0;
    io_request_t io_req;
    scalar_t read_data;
    display_t display;
    logic uart_tx;
    logic timer_int;

    // Stimulus table columns
    string row_name [MAX_ROWS];
    op_t row_op [MAX_ROWS];
    scalar_t row_addr [MAX_ROWS];
    scalar_t row_data [MAX_ROWS];
    logic [63:0] row_exp [MAX_ROWS];
    int row_count = 0;

    int cycle = 0;
    int cycle_limit = 0;
    int value_errors = 0;
    int other_errors = 0;
    int rx_count = 0;
    logic [7:0] rx_bytes [$];

    io_subsystem_top #(
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT)
    ) dut0(
        .clk(clk),
        .reset(reset),
        .io_req(io_req),
        .read_data(read_data),
        .display(display),
        .uart_tx(uart_tx),
        .timer_int(timer_int)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle >= cycle_limit)
        begin
            $display("Run stopped after %0d cycles with the table unfinished", cycle);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_scalar(input string name, input scalar_t expected, input scalar_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_display(input string name, input display_t expected,
                                 input display_t actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected)
        begin
            value_errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Serial receiver, samples each bit at its centre
    initial
    begin
        logic [7:0] rx_byte;
        @(negedge reset);
        forever
        begin
            @(negedge uart_tx);
            repeat (CLOCKS_PER_BIT / 2) @(negedge clk);
            check_bit("uart start bit", 1'b0, uart_tx);
            for (int i = 0; i < 8; i++)
            begin
                repeat (CLOCKS_PER_BIT) @(negedge clk);
                rx_byte[i] = uart_tx;
            end
            repeat (CLOCKS_PER_BIT) @(negedge clk);
            check_bit("uart stop bit", 1'b1, uart_tx);
            rx_bytes.push_back(rx_byte);
            rx_count++;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic bus_write(input scalar_t address, input scalar_t data);
        io_req = {1'b1, 1'b0, address, data};
        next_cycle();
        io_req = '0;
    endtask

    // Source latched at the edge, word valid for the whole following cycle
    task automatic bus_read(input scalar_t address, output scalar_t data);
        io_req = {1'b0, 1'b1, address, scalar_t'(0)};
        next_cycle();
        io_req = '0;
        data = read_data;
    endtask

    // Expected display after a write, from the register map
    function automatic display_t written(input display_t d, input scalar_t address,
                                         input scalar_t data);
        case (address)
            RED_LED_ADDR: d.red_led = data[17:0];
            GREEN_LED_ADDR: d.green_led = data[8:0];
            HEX0_ADDR: d.hex0 = data[6:0];
            HEX1_ADDR: d.hex1 = data[6:0];
            HEX2_ADDR: d.hex2 = data[6:0];
            HEX3_ADDR: d.hex3 = data[6:0];
            default: ;
        endcase
        return d;
    endfunction

    task automatic add_row(input string name, input op_t op, input scalar_t address,
                           input scalar_t data, input logic [63:0] expected);
        row_name[row_count] = name;
        row_op[row_count] = op;
        row_addr[row_count] = address;
        row_data[row_count] = data;
        row_exp[row_count] = expected;
        row_count++;
    endtask

    task automatic build_table();
        display_t model;
        scalar_t value;
        scalar_t display_addr [6] = '{RED_LED_ADDR, GREEN_LED_ADDR, HEX0_ADDR,
                                      HEX1_ADDR, HEX2_ADDR, HEX3_ADDR};
        model = {18'h0, 9'h0, {4{7'h7f}}};
        add_row("reset display", OP_DISPLAY, '0, '0, 64'(model));
        foreach (display_addr[i])
        begin
            value = $urandom;
            model = written(model, display_addr[i], value);
            add_row("display write", OP_WRITE, display_addr[i], value, '0);
            add_row("display field", OP_DISPLAY, '0, '0, 64'(model));
        end
        // Neither address belongs to a display register
        add_row("unmapped write", OP_WRITE, 32'h20, $urandom, '0);
        add_row("uart range write", OP_WRITE, 32'h44, $urandom, '0);
        add_row("display unchanged", OP_DISPLAY, '0, '0, 64'(model));
        add_row("uart status idle", OP_READ, UART_STATUS_ADDR, '0, 64'(0));
        value = $urandom % 256;
        add_row("uart frame a", OP_UART, UART_DATA_ADDR, value, 64'(value));
        value = $urandom % 256;
        add_row("uart frame b", OP_UART, UART_DATA_ADDR, value, 64'(value));
        add_row("timer run", OP_TIMER, TIMER_RELOAD_ADDR, 3 + $urandom % 10, '0);
        add_row("timer stopped count", OP_READ, TIMER_COUNT_ADDR, '0, 64'(0));
        // Nonzero timer count tells the timer word apart from the idle UART status
        add_row("timer restart", OP_WRITE, TIMER_RELOAD_ADDR, 32'h1000, '0);
        add_row("unmapped read", OP_READ, 32'h200, '0, 64'(0));
    endtask

    // One frame, a dropped write while busy, and the busy period
    task automatic send_frame(input string name, input logic [7:0] data);
        int rx_before;
        int start_cycle;
        scalar_t status;
        rx_before = rx_count;
        bus_write(UART_DATA_ADDR, scalar_t'(data));
        start_cycle = cycle;
        bus_read(UART_STATUS_ADDR, status);
        check_scalar({name, " busy"}, 32'h1, status);
        bus_write(UART_DATA_ADDR, scalar_t'(~data));
        wait (rx_count > rx_before);
        next_cycle();
        status = 32'h1;
        while (status[0] && cycle - start_cycle < 12 * CLOCKS_PER_BIT)
            bus_read(UART_STATUS_ADDR, status);
        check_scalar({name, " busy cycles"}, 10 * CLOCKS_PER_BIT, cycle - start_cycle);
        repeat (2 * CLOCKS_PER_BIT) next_cycle();
        check_scalar({name, " bytes received"}, rx_before + 1, rx_count);
        check_byte(name, data, rx_bytes[rx_before]);
    endtask

    // Ten periods of R+1 cycles, a count readback, then a stop
    task automatic run_timer(input string name, input scalar_t reload);
        int pulses;
        int start_cycle;
        scalar_t count;
        bus_write(TIMER_RELOAD_ADDR, reload);
        start_cycle = cycle;
        pulses = 0;
        repeat (10 * (reload + 1))
        begin
            @(negedge clk);
            pulses += timer_int;
        end
        check_scalar({name, " pulses"}, 10, pulses);
        next_cycle();
        bus_read(TIMER_COUNT_ADDR, count);
        // k edges into the run the count is R - k mod (R + 1)
        check_scalar({name, " count"}, reload - (cycle - start_cycle) % (reload + 1), count);
        bus_write(TIMER_RELOAD_ADDR, '0);
        pulses = 0;
        repeat (2 * (reload + 1))
        begin
            @(negedge clk);
            pulses += timer_int;
        end
        check_scalar({name, " stopped pulses"}, 0, pulses);
        next_cycle();
    endtask

    initial
    begin
        int seed;
        scalar_t word;
        display_t expected_display;
        seed = 85934;
        void'($urandom(seed));
        io_req = '0;
        build_table();
        cycle_limit = 10;
        for (int i = 0; i < row_count; i++)
        begin
            cycle_limit += 30;
            if (row_op[i] == OP_UART)
                cycle_limit += 12 * CLOCKS_PER_BIT;
            if (row_op[i] == OP_TIMER)
                cycle_limit += 40 * (row_data[i] + 1);
        end
        #2;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        check_bit("reset uart_tx", 1'b1, uart_tx);
        check_bit("reset timer_int", 1'b0, timer_int);
        for (int i = 0; i < row_count; i++)
        begin
            case (row_op[i])
                OP_WRITE:
                    bus_write(row_addr[i], row_data[i]);
                OP_READ:
                begin
                    bus_read(row_addr[i], word);
                    check_scalar(row_name[i], row_exp[i][31:0], word);
                end
                OP_DISPLAY:
                begin
                    expected_display = row_exp[i][$bits(display_t) - 1:0];
                    check_display(row_name[i], expected_display, display);
                end
                OP_UART:
                    send_frame(row_name[i], row_data[i][7:0]);
                default:
                    run_timer(row_name[i], row_data[i]);
            endcase
        end
        other_errors += dut0.props0.failure_count;
        $display("Value errors: %0d, assertion and other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/io_subsystem_props.sv */
// Concurrent checks on the I/O subsystem interrupt, serial line and reset display
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_props(
    input wire clk,
    input wire reset,
    input logic timer_int,
    input logic uart_tx,
    input io_pkg::scalar_t uart_read_data,
    input io_pkg::display_t display
);
    import io_pkg::*;

    // LEDs off, hex segments blank
    localparam display_t DISPLAY_RESET = {18'h0, 9'h0, {4{7'h7f}}};

    int failure_count = 0;

    timer_int_single_pulse: assert property (
        @(posedge clk) disable iff (reset) timer_int |=> !timer_int)
    else
    begin
        failure_count++;
        $error("timer_int stayed high for two cycles");
    end

    // Idle status means the line sits at the stop level
    uart_idle_line_high: assert property (
        @(posedge clk) disable iff (reset) !uart_read_data[0] |-> uart_tx)
    else
    begin
        failure_count++;
        $error("uart_tx low while the UART status shows idle");
    end

    display_held_in_reset: assert property (
        @(posedge clk) reset |-> display == DISPLAY_RESET)
    else
    begin
        failure_count++;
        $error("display left its reset value during reset");
    end

endmodule

bind io_subsystem_top io_subsystem_props props0(
    .clk(clk),
    .reset(reset),
    .timer_int(timer_int),
    .uart_tx(uart_tx),
    .uart_read_data(uart_read_data),
    .display(display)
);

`default_nettype wire

/* hw/io_subsystem_top.sv */
// I/O subsystem top level joining the bus decoder, interval timer and UART transmitter
`timescale 1ns/1ps
`default_nettype none

module io_subsystem_top #(
    parameter int CLOCKS_PER_BIT = 8
)(
    input wire clk,
    input wire reset,
    input io_pkg::io_request_t io_req,
    output io_pkg::scalar_t read_data,
    output io_pkg::display_t display,
    output logic uart_tx,
    output logic timer_int
);
    import io_pkg::*;

    scalar_t uart_read_data;
    scalar_t timer_read_data;

    // UART transmit path
    logic baud_run;
    logic bit_tick;
    logic load;
    logic [7:0] tx_byte;
    logic shift;

    io_bus_decoder io_bus_decoder0(
        .clk(clk),
        .reset(reset),
        .io_req(io_req),
        .uart_read_data(uart_read_data),
        .timer_read_data(timer_read_data),
        .display(display),
        .read_data(read_data)
    );

    interval_timer interval_timer0(
        .clk(clk),
        .reset(reset),
        .io_req(io_req),
        .read_data(timer_read_data),
        .timer_int(timer_int)
    );

    uart_tx_ctrl uart_tx_ctrl0(
        .clk(clk),
        .reset(reset),
        .io_req(io_req),
        .bit_tick(bit_tick),
        .baud_run(baud_run),
        .load(load),
        .tx_byte(tx_byte),
        .shift(shift),
        .read_data(uart_read_data)
    );

    uart_baud_timer #(
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT)
    ) uart_baud_timer0(
        .clk(clk),
        .reset(reset),
        .baud_run(baud_run),
        .bit_tick(bit_tick)
    );

    uart_tx_shift uart_tx_shift0(
        .clk(clk),
        .reset(reset),
        .load(load),
        .tx_byte(tx_byte),
        .shift(shift),
        .uart_tx(uart_tx)
    );

endmodule

`default_nettype wire

/* hw/io_bus_decoder.sv */
// I/O bus decoder holding the board display registers and the read-data select
`timescale 1ns/1ps
`default_nettype none

module io_bus_decoder(
    input wire clk,
    input wire reset,
    input io_pkg::io_request_t io_req,
    input io_pkg::scalar_t uart_read_data,
    input io_pkg::scalar_t timer_read_data,
    output io_pkg::display_t display,
    output io_pkg::scalar_t read_data
);
    import io_pkg::*;

    typedef enum logic {
        SRC_UART,
        SRC_TIMER
    } read_source_t;

    // All segments off
    localparam logic [6:0] HEX_BLANK = 7'h7f;

    read_source_t read_source;

    // Display registers, each masked to its field width
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            display.red_led <= '0;
            display.green_led <= '0;
            display.hex0 <= HEX_BLANK;
            display.hex1 <= HEX_BLANK;
            display.hex2 <= HEX_BLANK;
            display.hex3 <= HEX_BLANK;
        end
        else if (io_req.write_en)
        begin
            case (io_req.address)
                RED_LED_ADDR:
                    display.red_led <= io_req.write_data[17:0];
                GREEN_LED_ADDR:
                    display.green_led <= io_req.write_data[8:0];
                HEX0_ADDR:
                    display.hex0 <= io_req.write_data[6:0];
                HEX1_ADDR:
                    display.hex1 <= io_req.write_data[6:0];
                HEX2_ADDR:
                    display.hex2 <= io_req.write_data[6:0];
                HEX3_ADDR:
                    display.hex3 <= io_req.write_data[6:0];
                default:
                    ;
            endcase
        end
    end

    // Latch the source on every cycle so the data is ready one cycle after the address
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            read_source <= SRC_UART;
        else
        begin
            case (io_req.address[31:4])
                UART_STATUS_ADDR[31:4]:
                    read_source <= SRC_UART;
                TIMER_COUNT_ADDR[31:4]:
                    read_source <= SRC_TIMER;
                // Unmapped space reads back the UART status
                default:
                    read_source <= SRC_UART;
            endcase
        end
    end

    always_comb
    begin
        case (read_source)
            SRC_TIMER:
                read_data = timer_read_data;
            default:
                read_data = uart_read_data;
        endcase
    end

endmodule

`default_nettype wire

/* hw/interval_timer.sv */
// Interval timer that counts down from a reload value and pulses an interrupt at zero
`timescale 1ns/1ps
`default_nettype none

module interval_timer(
    input wire clk,
    input wire reset,
    input io_pkg::io_request_t io_req,
    output io_pkg::scalar_t read_data,
    output logic timer_int
);
    import io_pkg::*;

    scalar_t reload_value;
    scalar_t count;
    logic running;
    logic reload_write;

    assign reload_write = io_req.write_en && io_req.address == TIMER_RELOAD_ADDR;

    always_ff @(posedge clk)
    begin
        if (reload_write)
            reload_value <= io_req.write_data;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            running <= 1'b0;
            count <= '0;
        end
        else if (reload_write)
        begin
            // Zero reload parks the counter
            running <= io_req.write_data != '0;
            count <= io_req.write_data;
        end
        else if (running)
        begin
            if (count == '0)
                count <= reload_value;
            else
                count <= count - 1'b1;
        end
    end

    // One cycle at zero, so the period is reload + 1
    assign timer_int = running && count == '0;

    assign read_data = count;

endmodule

`default_nettype wire

/* hw/uart/uart_tx_ctrl.sv */
// UART transmit controller that sequences one frame per data write and reports busy
`timescale 1ns/1ps
`default_nettype none

module uart_tx_ctrl(
    input wire clk,
    input wire reset,
    input io_pkg::io_request_t io_req,
    input logic bit_tick,
    output logic baud_run,
    output logic load,
    output logic [7:0] tx_byte,
    output logic shift,
    output io_pkg::scalar_t read_data
);
    import io_pkg::*;

    // Start, eight data bits, stop
    localparam int FRAME_BITS = 10;

    typedef enum logic {
        TX_IDLE,
        TX_SENDING
    } tx_state_t;

    tx_state_t state;
    logic [3:0] bit_count;
    logic busy;
    logic last_bit;

    assign busy = state == TX_SENDING;
    assign last_bit = bit_count == 4'(FRAME_BITS - 1);

    // Writes while a frame is in flight are dropped
    assign load = !busy && io_req.write_en && io_req.address == UART_DATA_ADDR;
    assign tx_byte = io_req.write_data[7:0];

    assign baud_run = busy;
    assign shift = busy && bit_tick;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= TX_IDLE;
            bit_count <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    if (load)
                    begin
                        state <= TX_SENDING;
                        bit_count <= '0;
                    end
                end

                TX_SENDING:
                begin
                    if (bit_tick)
                    begin
                        // Stop bit has run its full period
                        if (last_bit)
                            state <= TX_IDLE;
                        else
                            bit_count <= bit_count + 1'b1;
                    end
                end

                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    // Status word, busy in bit 0
    assign read_data = {{31{1'b0}}, busy};

endmodule

`default_nettype wire

/* hw/uart/uart_tx_shift.sv */
// UART frame shift register that drives the serial transmit line
`timescale 1ns/1ps
`default_nettype none

module uart_tx_shift(
    input wire clk,
    input wire reset,
    input logic load,
    input logic [7:0] tx_byte,
    input logic shift,
    output logic uart_tx
);
    // Stop, data, start from high bit to low bit
    logic [9:0] frame;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            // Line idles high
            frame <= '1;
        end
        else if (load)
        begin
            frame <= {1'b1, tx_byte, 1'b0};
        end
        else if (shift)
        begin
            // Ones fill behind the stop bit
            frame <= {1'b1, frame[9:1]};
        end
    end

    assign uart_tx = frame[0];

endmodule

`default_nettype wire

/* hw/uart/uart_baud_timer.sv */
// Baud timer that gives one tick at the end of each serial bit period
`timescale 1ns/1ps
`default_nettype none

module uart_baud_timer #(
    parameter int CLOCKS_PER_BIT = 8
)(
    input wire clk,
    input wire reset,
    input logic baud_run,
    output logic bit_tick
);
    localparam int COUNT_WIDTH = $clog2(CLOCKS_PER_BIT);
    localparam logic [COUNT_WIDTH - 1:0] LAST_COUNT = COUNT_WIDTH'(CLOCKS_PER_BIT - 1);

    logic [COUNT_WIDTH - 1:0] clock_count;
    logic period_end;

    assign period_end = clock_count == LAST_COUNT;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            clock_count <= '0;
        else if (!baud_run || period_end)
            clock_count <= '0;
        else
            clock_count <= clock_count + 1'b1;
    end

    // Counter starts at zero when run goes high, so the first tick
    // lands on the last cycle of the start bit
    assign bit_tick = baud_run && period_end;

endmodule

`default_nettype wire

/* common/io_pkg.sv */
// I/O subsystem package with bus word, request, display types and register map
`default_nettype none

package io_pkg;

    // One word on the processor I/O bus
    typedef logic [31:0] scalar_t;

    // A single bus cycle's request from the processor side
    typedef struct packed {
        logic write_en;
        logic read_en;
        scalar_t address;
        scalar_t write_data;
    } io_request_t;

    // Everything shown on the board
    // Hex digits use active-low segments
    typedef struct packed {
        logic [17:0] red_led;
        logic [8:0] green_led;
        logic [6:0] hex3;
        logic [6:0] hex2;
        logic [6:0] hex1;
        logic [6:0] hex0;
    } display_t;

    // Display registers
    localparam scalar_t RED_LED_ADDR = 32'h00;
    localparam scalar_t GREEN_LED_ADDR = 32'h04;
    localparam scalar_t HEX0_ADDR = 32'h08;
    localparam scalar_t HEX1_ADDR = 32'h0c;
    localparam scalar_t HEX2_ADDR = 32'h10;
    localparam scalar_t HEX3_ADDR = 32'h14;

    // UART transmitter
    localparam scalar_t UART_STATUS_ADDR = 32'h40;
    localparam scalar_t UART_DATA_ADDR = 32'h48;

    // Interval timer
    localparam scalar_t TIMER_RELOAD_ADDR = 32'h100;
    localparam scalar_t TIMER_COUNT_ADDR = 32'h104;

endpackage

`default_nettype wire
